//--- design/lsu_mem_pkg.sv
package lsu_mem_pkg;

    // bus geometry
    parameter int data_w = 32;
    parameter int strb_w = data_w / 8;
    parameter int addr_w = 32;

    // first byte of the memory window, same as the core's reset vector
    parameter logic [addr_w-1:0] mem_base = 32'h8000_0000;

    // read and write response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_decerr = 2'b11
    } resp_t;

endpackage

//--- design/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine #(
    parameter int read_latency = 5
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [lsu_mem_pkg::addr_w-1:0] araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [lsu_mem_pkg::data_w-1:0] rdata,
    output lsu_mem_pkg::resp_t             rresp,
    output logic                           rvalid,
    input  logic                           rready,
    output logic                           rd_en,
    output logic [lsu_mem_pkg::addr_w-1:0] rd_addr,
    input  logic [lsu_mem_pkg::data_w-1:0] rd_data,
    input  logic                           rd_hit
);
    import lsu_mem_pkg::*;

    localparam int cnt_w = $clog2(read_latency + 1);

    logic             ar_hs;
    logic             r_hs;
    logic             rd_ack;
    logic [cnt_w-1:0] cnt;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // reopen only once the previous response is gone
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b1;
        end else if (ar_hs) begin
            arready <= 1'b0;
        end else if (!arready && !rvalid && cnt == '0) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_addr <= araddr;
        end
    end

    // one bank strobe per request, answer comes a cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en  <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            rd_en  <= ar_hs;
            rd_ack <= rd_en;
        end
    end

    // latency countdown
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            rvalid <= 1'b0;
        end else begin
            if (ar_hs) begin
                cnt <= cnt_w'(read_latency);
            end else if (cnt != '0) begin
                cnt <= cnt - cnt_w'(1);
            end
            if (cnt == cnt_w'(1)) begin
                rvalid <= 1'b1;
            end else if (r_hs) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload, frozen until the next request
    always_ff @(posedge clk) begin
        if (rd_ack) begin
            rdata <= rd_data;
            rresp <= rd_hit ? resp_okay : resp_decerr;
        end
    end

    // response must not move under back-pressure
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    // single outstanding read
    a_ar_closed: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> !arready);

endmodule

//--- design/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [lsu_mem_pkg::addr_w-1:0] awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [lsu_mem_pkg::data_w-1:0] wdata,
    input  logic [lsu_mem_pkg::strb_w-1:0] wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output lsu_mem_pkg::resp_t             bresp,
    output logic                           bvalid,
    input  logic                           bready,
    output logic                           wr_en,
    output logic [lsu_mem_pkg::addr_w-1:0] wr_addr,
    output logic [lsu_mem_pkg::data_w-1:0] wr_data,
    output logic [lsu_mem_pkg::strb_w-1:0] wr_strb,
    input  logic                           wr_hit
);
    import lsu_mem_pkg::*;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic aw_taken;
    logic w_taken;
    logic idle;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;
    assign idle  = !aw_taken && !w_taken && !bvalid;

    // commit as soon as both halves are in
    assign wr_en = aw_taken && w_taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b1;
        end else if (aw_hs) begin
            awready <= 1'b0;
        end else if (!awready && idle) begin
            awready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wready <= 1'b1;
        end else if (w_hs) begin
            wready <= 1'b0;
        end else if (!wready && idle) begin
            wready <= 1'b1;
        end
    end

    // address and data may arrive in either order
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
        end else if (wr_en) begin
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_taken <= 1'b1;
            end
            if (w_hs) begin
                w_taken <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_addr <= awaddr;
        end
        if (w_hs) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
    end

    // bank decode picks the response in the commit cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_en) begin
            bvalid <= 1'b1;
        end else if (b_hs) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            bresp <= wr_hit ? resp_okay : resp_decerr;
        end
    end

    // exactly one commit per write, then straight to the response
    a_commit_once: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> bvalid && !wr_en && !aw_taken && !w_taken);

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

//--- design/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
    parameter int mem_words = 1024
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rd_en,
    input  logic [lsu_mem_pkg::addr_w-1:0] rd_addr,
    output logic [lsu_mem_pkg::data_w-1:0] rd_data,
    output logic                           rd_hit,
    input  logic                           wr_en,
    input  logic [lsu_mem_pkg::addr_w-1:0] wr_addr,
    input  logic [lsu_mem_pkg::data_w-1:0] wr_data,
    input  logic [lsu_mem_pkg::strb_w-1:0] wr_strb,
    output logic                           wr_hit
);
    import lsu_mem_pkg::*;

    localparam int idx_w = $clog2(mem_words);

    logic [data_w-1:0] mem [mem_words];
    logic [addr_w-1:0] rd_off;
    logic [addr_w-1:0] wr_off;
    logic [idx_w-1:0]  rd_idx;
    logic [idx_w-1:0]  wr_idx;
    logic              rd_in;
    logic              collide;

    // below the base the offset wraps high, so one test covers both ends
    assign rd_off  = rd_addr - mem_base;
    assign wr_off  = wr_addr - mem_base;
    assign rd_idx  = rd_off[idx_w+1:2];
    assign wr_idx  = wr_off[idx_w+1:2];
    assign rd_in   = (rd_off[addr_w-1:idx_w+2] == '0);
    assign wr_hit  = (wr_off[addr_w-1:idx_w+2] == '0);
    assign collide = wr_en && wr_hit && (wr_idx == rd_idx);

    // strobed byte write
    always_ff @(posedge clk) begin
        if (wr_en && wr_hit) begin
            for (int b = 0; b < strb_w; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // registered read, write-first on a same-word collision
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int b = 0; b < strb_w; b++) begin
                if (!rd_in) begin
                    rd_data[8*b +: 8] <= '0;
                end else if (collide && wr_strb[b]) begin
                    rd_data[8*b +: 8] <= wr_data[8*b +: 8];
                end else begin
                    rd_data[8*b +: 8] <= mem[rd_idx][8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hit <= 1'b0;
        end else if (rd_en) begin
            rd_hit <= rd_in;
        end
    end

    // a commit with no bytes enabled means the master sent an empty beat
    a_strb_nonzero: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_strb != '0);

endmodule

//--- design/lsu_sram_top.sv
`timescale 1ns/1ps

module lsu_sram_top #(
    parameter int mem_words    = 1024,
    parameter int read_latency = 5
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [lsu_mem_pkg::addr_w-1:0] araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [lsu_mem_pkg::data_w-1:0] rdata,
    output lsu_mem_pkg::resp_t             rresp,
    output logic                           rvalid,
    input  logic                           rready,
    input  logic [lsu_mem_pkg::addr_w-1:0] awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [lsu_mem_pkg::data_w-1:0] wdata,
    input  logic [lsu_mem_pkg::strb_w-1:0] wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output lsu_mem_pkg::resp_t             bresp,
    output logic                           bvalid,
    input  logic                           bready
);
    import lsu_mem_pkg::*;

    // read port of the bank
    logic              rd_en;
    logic [addr_w-1:0] rd_addr;
    logic [data_w-1:0] rd_data;
    logic              rd_hit;

    // write port of the bank
    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;
    logic [strb_w-1:0] wr_strb;
    logic              wr_hit;

    axi_read_engine #(
        .read_latency(read_latency)
    ) u_rd (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_hit  (rd_hit)
    );

    axi_write_engine u_wr (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .wr_hit  (wr_hit)
    );

    sram_bank #(
        .mem_words(mem_words)
    ) u_bank (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_hit  (rd_hit),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .wr_hit  (wr_hit)
    );

endmodule

//--- sim/lsu_sram_checker.sv
`timescale 1ns/1ps

module lsu_sram_checker #(
    parameter int mem_words    = 1024,
    parameter int read_latency = 5
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [lsu_mem_pkg::addr_w-1:0] araddr,
    input  logic                           arvalid,
    input  logic                           arready,
    input  logic [lsu_mem_pkg::data_w-1:0] rdata,
    input  lsu_mem_pkg::resp_t             rresp,
    input  logic                           rvalid,
    input  logic                           rready,
    input  logic [lsu_mem_pkg::addr_w-1:0] awaddr,
    input  logic                           awvalid,
    input  logic                           awready,
    input  logic [lsu_mem_pkg::data_w-1:0] wdata,
    input  logic [lsu_mem_pkg::strb_w-1:0] wstrb,
    input  logic                           wvalid,
    input  logic                           wready,
    input  lsu_mem_pkg::resp_t             bresp,
    input  logic                           bvalid,
    input  logic                           bready,
    output int                             errors,
    output int                             reads_seen,
    output int                             writes_seen
);
    import lsu_mem_pkg::*;

    logic [data_w-1:0] ref_mem [int];
    logic [addr_w-1:0] aw_q [$];
    logic [data_w-1:0] wd_q [$];
    logic [strb_w-1:0] ws_q [$];
    logic [data_w-1:0] exp_data_q [$];
    resp_t             exp_resp_q [$];

    int                err_n = 0;
    int                n_r = 0;
    int                n_w = 0;
    int                lat = 0;
    bit                lat_run = 1'b0;
    bit                r_stall = 1'b0;
    bit                b_stall = 1'b0;
    bit                ar_open = 1'b1;
    bit                aw_open = 1'b1;
    bit                w_open = 1'b1;
    bit                r_done = 1'b0;
    bit                b_done = 1'b0;
    bit                r_prev = 1'b0;
    bit                b_prev = 1'b0;
    logic [data_w-1:0] held_rdata;
    resp_t             held_rresp;
    resp_t             held_bresp;

    assign errors      = err_n;
    assign reads_seen  = n_r;
    assign writes_seen = n_w;

    function automatic bit in_window(input logic [addr_w-1:0] addr);
        logic [addr_w-1:0] off;
        off = addr - mem_base;
        return (off >> 2) < 32'(mem_words);
    endfunction

    function automatic int word_index(input logic [addr_w-1:0] addr);
        logic [addr_w-1:0] off;
        off = addr - mem_base;
        return int'(off >> 2);
    endfunction

    function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old,
                                                      input logic [data_w-1:0] data,
                                                      input logic [strb_w-1:0] strb);
        logic [data_w-1:0] v;
        v = old;
        for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
                v[8*b +: 8] = data[8*b +: 8];
            end
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
        err_n++;
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t: %s", $time, what);
        err_n++;
    endtask

    always @(posedge clk) begin
        logic [data_w-1:0] d;
        logic [addr_w-1:0] a;
        logic [strb_w-1:0] s;
        resp_t             r;
        if (!rst) begin
            // payload must hold while the master stalls
            if (r_stall) begin
                if (!rvalid) begin
                    report_problem("rvalid dropped without an R handshake");
                end else begin
                    if (rdata !== held_rdata) report_mismatch("rdata", held_rdata, rdata);
                    if (rresp !== held_rresp) report_mismatch("rresp", 32'(held_rresp), 32'(rresp));
                end
            end
            if (b_stall) begin
                if (!bvalid) begin
                    report_problem("bvalid dropped without a B handshake");
                end else if (bresp !== held_bresp) begin
                    report_mismatch("bresp", 32'(held_bresp), 32'(bresp));
                end
            end

            // readies close at their own handshake and reopen an edge after the response
            if (arready !== ar_open) begin
                report_mismatch("arready", 32'(ar_open), 32'(arready));
            end
            if (awready !== aw_open) begin
                report_mismatch("awready", 32'(aw_open), 32'(awready));
            end
            if (wready !== w_open) begin
                report_mismatch("wready", 32'(w_open), 32'(wready));
            end

            if (lat_run) begin
                lat++;
                if (rvalid) begin
                    if (lat - 1 != read_latency) begin
                        report_mismatch("rvalid latency", 32'(read_latency), 32'(lat - 1));
                    end
                    lat_run = 1'b0;
                end
            end

            // every offered response counts, so a repeated one shows
            if (rvalid && !r_prev) begin
                n_r++;
            end
            if (bvalid && !b_prev) begin
                n_w++;
            end

            if (arvalid && arready) begin
                if (in_window(araddr)) begin
                    d = ref_mem.exists(word_index(araddr)) ? ref_mem[word_index(araddr)] : 'x;
                    exp_data_q.push_back(d);
                    exp_resp_q.push_back(resp_okay);
                end else begin
                    exp_data_q.push_back('0);
                    exp_resp_q.push_back(resp_decerr);
                end
                lat = 0;
                lat_run = 1'b1;
            end
            if (awvalid && awready) aw_q.push_back(awaddr);
            if (wvalid && wready) begin
                wd_q.push_back(wdata);
                ws_q.push_back(wstrb);
            end

            if (rvalid && rready) begin
                if (exp_data_q.size() == 0) begin
                    report_problem("R handshake with no read outstanding");
                end else begin
                    d = exp_data_q.pop_front();
                    r = exp_resp_q.pop_front();
                    if (rdata !== d) report_mismatch("rdata", d, rdata);
                    if (rresp !== r) report_mismatch("rresp", 32'(r), 32'(rresp));
                end
            end

            if (bvalid && bready) begin
                if (aw_q.size() == 0 || wd_q.size() == 0) begin
                    report_problem("B handshake with no complete write outstanding");
                end else begin
                    a = aw_q.pop_front();
                    d = wd_q.pop_front();
                    s = ws_q.pop_front();
                    r = in_window(a) ? resp_okay : resp_decerr;
                    if (bresp !== r) report_mismatch("bresp", 32'(r), 32'(bresp));
                    // out-of-window writes leave the reference untouched
                    if (r == resp_okay) begin
                        ref_mem[word_index(a)] = merge_bytes(
                            ref_mem.exists(word_index(a)) ? ref_mem[word_index(a)] : '0, d, s);
                    end
                end
            end

            if (arvalid && arready) begin
                ar_open = 1'b0;
            end else if (r_done) begin
                ar_open = 1'b1;
            end
            if (awvalid && awready) begin
                aw_open = 1'b0;
            end else if (b_done) begin
                aw_open = 1'b1;
            end
            if (wvalid && wready) begin
                w_open = 1'b0;
            end else if (b_done) begin
                w_open = 1'b1;
            end
            r_done = rvalid && rready;
            b_done = bvalid && bready;

            r_prev     = rvalid;
            b_prev     = bvalid;
            r_stall    = rvalid && !rready;
            b_stall    = bvalid && !bready;
            held_rdata = rdata;
            held_rresp = rresp;
            held_bresp = bresp;
        end
    end

endmodule

//--- sim/tb_lsu_sram.sv
`timescale 1ns/1ps

module tb_lsu_sram;
    import lsu_mem_pkg::*;

    localparam int mem_words    = 1024;
    localparam int read_latency = 5;
    localparam int max_stall    = 7;
    localparam int n_ops        = 90;
    localparam int cycle_limit  = n_ops * (read_latency + max_stall + 10);

    logic              clk;
    logic              rst;
    logic [addr_w-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [data_w-1:0] rdata;
    resp_t             rresp;
    logic              rvalid;
    logic              rready;
    logic [addr_w-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    resp_t             bresp;
    logic              bvalid;
    logic              bready;

    int          check_errors;
    int          reads_seen;
    int          writes_seen;
    int          reads_issued = 0;
    int          writes_issued = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'd97598;

    lsu_sram_top #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) DUT (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    lsu_sram_checker #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) watcher (
        .clk         (clk),
        .rst         (rst),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .errors      (check_errors),
        .reads_seen  (reads_seen),
        .writes_seen (writes_seen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [addr_w-1:0] word_addr(input int k);
        return mem_base + 32'(k * 4);
    endfunction

    task automatic read_word(input logic [addr_w-1:0] addr, input int stall);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!(arvalid && arready));
        arvalid <= 1'b0;
        while (!rvalid) @(posedge clk);
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        do @(posedge clk); while (!(rvalid && rready));
        rready <= 1'b0;
        reads_issued++;
    endtask

    // order 0 sends AW first, 1 sends W first, 2 sends both together
    task automatic write_word(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                              input logic [strb_w-1:0] strb, input int order,
                              input int gap, input int stall);
        int aw_at;
        int w_at;
        int c;
        bit aw_done;
        bit w_done;
        aw_at   = (order == 1) ? gap : 0;
        w_at    = (order == 0) ? gap : 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        c       = 0;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end else if (!aw_done && !awvalid && c == aw_at) begin
                awaddr  <= addr;
                awvalid <= 1'b1;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end else if (!w_done && !wvalid && c == w_at) begin
                wdata  <= data;
                wstrb  <= strb;
                wvalid <= 1'b1;
            end
            c++;
        end
        while (!bvalid) @(posedge clk);
        repeat (stall) @(posedge clk);
        bready <= 1'b1;
        do @(posedge clk); while (!(bvalid && bready));
        bready <= 1'b0;
        writes_issued++;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0]       r;
        logic [addr_w-1:0] a;
        logic [strb_w-1:0] s;
        int                order;
        int                tb_errors;
        tb_errors = 0;
        rst     = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // fill the test words so every later read is defined
        for (int k = 0; k < 16; k++) begin
            write_word(word_addr(k), rand_bits(32), 4'hf, 0, 1, 0);
        end
        read_word(word_addr(0), 0);

        write_word(word_addr(3), 32'hdead_beef, 4'b0101, 0, 1, 0);
        read_word(word_addr(3), 0);

        write_word(word_addr(5), 32'h1111_2222, 4'hf, 0, 2, 1);
        write_word(word_addr(6), 32'h3333_4444, 4'hf, 1, 2, 1);
        write_word(word_addr(7), 32'h5555_6666, 4'hf, 2, 0, 1);
        read_word(word_addr(5), 0);
        read_word(word_addr(6), 0);
        read_word(word_addr(7), 0);

        // just below and just above the window
        write_word(mem_base - 32'd4, 32'hffff_ffff, 4'hf, 0, 1, 0);
        write_word(mem_base + 32'(mem_words * 4), 32'hffff_ffff, 4'hf, 1, 1, 0);
        read_word(mem_base - 32'd4, 0);
        read_word(mem_base + 32'(mem_words * 4), 0);
        read_word(word_addr(0), 0);

        for (int i = 0; i < 60; i++) begin
            r = rand_bits(3);
            if (r[2:0] == 3'd0) begin
                r = rand_bits(4);
                if (r[0]) begin
                    a = mem_base - {27'd0, r[3:1], 2'b00} - 32'd4;
                end else begin
                    a = mem_base + 32'(mem_words * 4) + {27'd0, r[3:1], 2'b00};
                end
            end else begin
                r = rand_bits(4);
                a = word_addr(int'(r[3:0]));
            end
            r = rand_bits(1);
            if (r[0]) begin
                r = rand_bits(4);
                s = (r[3:0] == 4'h0) ? 4'hf : r[3:0];
                r = rand_bits(2);
                order = (r[1:0] == 2'd3) ? 2 : int'(r[1:0]);
                r = rand_bits(2);
                write_word(a, rand_bits(32), s, order, 1 + int'(r[1:0]),
                           int'(rand_bits(3)));
            end else begin
                read_word(a, int'(rand_bits(3)));
            end
        end

        repeat (4) @(posedge clk);
        if (reads_seen != reads_issued || writes_seen != writes_issued) begin
            $display("transfer count wrong: issued %0d reads %0d writes, saw %0d reads %0d writes",
                     reads_issued, writes_issued, reads_seen, writes_seen);
            tb_errors++;
        end
        $display("errors: checker %0d, testbench %0d", check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
design/lsu_mem_pkg.sv
design/axi_read_engine.sv
design/axi_write_engine.sv
design/sram_bank.sv
design/lsu_sram_top.sv
sim/lsu_sram_checker.sv
sim/tb_lsu_sram.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_lsu_sram \
    -f sim.f \
    -o tb_lsu_sram

./obj_dir/tb_lsu_sram | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    exit 1
fi
exit 0
